/* logic/mbist_pkg.sv */
////////////////////
// MBIST shared types
// Widths, address and data vectors, March and FSM enums,
// memory request and failure report structs
////////////////////
`default_nettype none

package mbist_pkg;

  // Physical SRAM geometry
  localparam int MBIST_ADDR_WD = 9;
  localparam int MBIST_DATA_WD = 32;

  // One scan-out slot per repair entry
  localparam int MBIST_SLOT_WD = 16;

  typedef logic [MBIST_ADDR_WD-1:0] addr_t;
  typedef logic [MBIST_DATA_WD-1:0] data_t;

  // March elements in run order
  typedef enum logic [1:0] {
    W0_UP   = 2'd0,
    R0W1_UP = 2'd1,
    R1W0_DN = 2'd2,
    R0_DN   = 2'd3
  } march_elem_e;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DRAIN = 2'd2,
    DONE  = 2'd3
  } ctrl_state_e;

  // One SRAM access, read when we is low
  typedef struct packed {
    logic  cs;
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  // One failing logical address
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } err_rpt_t;

endpackage

`default_nettype wire

/* logic/mbist_addr_gen.sv */
////////////////////
// MBIST address counter
// Up or down count over the main range with end detection
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mbist_addr_gen
  import mbist_pkg::*;
#(
  parameter int ADDR_END = 2**MBIST_ADDR_WD - 5
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic load_up,
  input  wire logic load_dn,
  input  wire logic step,
  output addr_t     addr,
  output logic      last
);

  localparam addr_t END_ADDR = addr_t'(ADDR_END);

  // Direction of the most recent load
  logic dir_dn;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr   <= '0;
      dir_dn <= 1'b0;
    end else if (load_up) begin
      addr   <= '0;
      dir_dn <= 1'b0;
    end else if (load_dn) begin
      addr   <= END_ADDR;
      dir_dn <= 1'b1;
    end else if (step) begin
      addr <= dir_dn ? addr - 1'b1 : addr + 1'b1;
    end
  end

  // End of range in the current direction
  assign last = dir_dn ? (addr == '0) : (addr == END_ADDR);

endmodule

`default_nettype wire

/* logic/mbist_ctrl.sv */
////////////////////
// MBIST March sequencer
// Steps through W0 up, R0W1 up, R1W0 down, R0 down
// and drives the SRAM request and expected read data
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mbist_ctrl
  import mbist_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     start,
  input  wire addr_t    addr,
  input  wire logic     last,
  output logic          load_up,
  output logic          load_dn,
  output logic          step,
  output mem_req_t      req,
  output logic          rd_issue,
  output data_t         exp_data,
  output logic          busy,
  output logic          done
);

  ctrl_state_e state;
  march_elem_e elem;
  // Low for the read, high for the write of a read-write element
  logic        phase;
  logic        drain_cnt;

  logic        run;
  logic        single_op;
  logic        op_done;
  logic        elem_end;
  logic        launch;
  logic        wr_op;

  ////////////////////
  // Decode
  ////////////////////
  assign run       = (state == RUN);
  assign single_op = (elem == W0_UP) || (elem == R0_DN);
  // Last operation on the current address
  assign op_done   = single_op || phase;
  assign elem_end  = run && op_done && last;
  assign launch    = start && ((state == IDLE) || (state == DONE));

  // Address counter control, loads win over step
  assign step    = run && op_done && !last;
  assign load_up = launch || (elem_end && (elem == W0_UP));
  assign load_dn = elem_end && ((elem == R0W1_UP) || (elem == R1W0_DN));

  // Writes in W0 and in the second half of read-write elements
  assign wr_op = run && ((elem == W0_UP) || (!single_op && phase));

  always_comb begin
    req.cs    = run;
    req.we    = wr_op;
    req.addr  = addr;
    // Background of ones only written in R0W1
    req.wdata = (elem == R0W1_UP) ? '1 : '0;
  end

  assign rd_issue = run && !wr_op;
  // Only R1W0 expects ones
  assign exp_data = (elem == R1W0_DN) ? '1 : '0;

  assign busy = run || (state == DRAIN);
  assign done = (state == DONE);

  ////////////////////
  // State machine
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      elem      <= W0_UP;
      phase     <= 1'b0;
      drain_cnt <= 1'b0;
    end else begin
      case (state)
        IDLE, DONE: begin
          if (launch) begin
            state <= RUN;
            elem  <= W0_UP;
            phase <= 1'b0;
          end
        end
        RUN: begin
          // Alternate read and write in R0W1 and R1W0
          if (!single_op) begin
            phase <= !phase;
          end
          if (elem_end) begin
            case (elem)
              W0_UP:   elem <= R0W1_UP;
              R0W1_UP: elem <= R1W0_DN;
              R1W0_DN: elem <= R0_DN;
              default: begin
                state     <= DRAIN;
                drain_cnt <= 1'b0;
              end
            endcase
          end
        end
        DRAIN: begin
          // Two cycles let the last report reach the table
          drain_cnt <= 1'b1;
          if (drain_cnt) begin
            state <= DONE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/mbist_data_cmp.sv */
////////////////////
// MBIST read comparator
// Delays expected data by the read latency
// and reports the logical address on a mismatch
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mbist_data_cmp
  import mbist_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  rd_issue,
  input  wire data_t exp_data,
  input  wire addr_t addr,
  input  wire data_t rdata,
  output err_rpt_t   err_rpt
);

  // Read issued last cycle, data on rdata now
  logic  rd_q;
  data_t exp_q;
  addr_t addr_q;

  logic  err_valid;
  addr_t err_addr;
  logic  mismatch;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= rd_issue;
    end
  end

  always_ff @(posedge clk) begin
    exp_q  <= exp_data;
    addr_q <= addr;
  end

  assign mismatch = rd_q && (rdata != exp_q);

  // Report registered one cycle after the data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_valid <= 1'b0;
    end else begin
      err_valid <= mismatch;
    end
  end

  always_ff @(posedge clk) begin
    if (mismatch) begin
      err_addr <= addr_q;
    end
  end

  assign err_rpt = '{valid: err_valid, addr: err_addr};

endmodule

`default_nettype wire

/* logic/mbist_repair_addr.sv */
////////////////////
// MBIST address repair
// Records failing addresses, remaps them onto spare rows
// and shifts the table out in 16-bit slots
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mbist_repair_addr
  import mbist_pkg::*;
#(
  parameter int ERR_LIMIT = 4,
  parameter int ADDR_END  = 2**MBIST_ADDR_WD - ERR_LIMIT - 1
) (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire err_rpt_t err_rpt,
  input  wire addr_t    addr_in,
  output addr_t         addr_out,
  output logic          repair_fail,
  input  wire logic     scan_shift,
  input  wire logic     sdi,
  output logic          sdo
);

  // Spare rows sit just above the main range
  localparam int REPAIR_START = ADDR_END + 1;
  localparam int ERR_CNT_WD   = $clog2(ERR_LIMIT + 1);
  localparam int SCAN_BITS    = ERR_LIMIT * MBIST_SLOT_WD;
  localparam int SHIFT_CNT_WD = $clog2(SCAN_BITS + 1);
  localparam int SLOT_BITS    = $clog2(MBIST_SLOT_WD);
  localparam int PAD_WD       = MBIST_SLOT_WD - MBIST_ADDR_WD;

  logic [ERR_CNT_WD-1:0]    err_cnt;
  addr_t                    tbl [ERR_LIMIT];

  logic [SHIFT_CNT_WD-1:0]  shift_cnt;
  logic [MBIST_SLOT_WD-1:0] shift_reg;
  logic [SHIFT_CNT_WD-SLOT_BITS-1:0] next_slot;
  addr_t                    next_entry;

  ////////////////////
  // Table fill
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_cnt     <= '0;
      repair_fail <= 1'b0;
      for (int i = 0; i < ERR_LIMIT; i++) begin
        tbl[i] <= '0;
      end
    end else if (err_rpt.valid) begin
      if (err_cnt < ERR_LIMIT) begin
        err_cnt <= err_cnt + 1'b1;
        for (int i = 0; i < ERR_LIMIT; i++) begin
          if (i == err_cnt) begin
            tbl[i] <= err_rpt.addr;
          end
        end
      end else begin
        // Out of spares, sticky until reset
        repair_fail <= 1'b1;
      end
    end
  end

  // Remap, lowest matching entry wins
  always_comb begin
    addr_out = addr_in;
    for (int i = ERR_LIMIT - 1; i >= 0; i--) begin
      if ((i < err_cnt) && (addr_in == tbl[i])) begin
        addr_out = addr_t'(REPAIR_START + i);
      end
    end
  end

  ////////////////////
  // Scan-out
  ////////////////////
  assign next_slot = shift_cnt[SHIFT_CNT_WD-1:SLOT_BITS] + 1'b1;

  // Entry for the slot after the current one
  always_comb begin
    next_entry = '0;
    for (int i = 0; i < ERR_LIMIT; i++) begin
      if (i == next_slot) begin
        next_entry = tbl[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_cnt <= '0;
      shift_reg <= '0;
    end else if (!scan_shift) begin
      // Park on entry 0
      shift_cnt <= '0;
      shift_reg <= {{PAD_WD{1'b0}}, tbl[0]};
    end else if (shift_cnt < SCAN_BITS) begin
      shift_cnt <= shift_cnt + 1'b1;
      if ((&shift_cnt[SLOT_BITS-1:0]) && (next_slot < ERR_LIMIT)) begin
        shift_reg <= {{PAD_WD{1'b0}}, next_entry};
      end else begin
        shift_reg <= {sdi, shift_reg[MBIST_SLOT_WD-1:1]};
      end
    end
  end

  // LSB first
  assign sdo = shift_reg[0];

endmodule

`default_nettype wire

/* logic/mbist_top.sv */
////////////////////
// MBIST subsystem top
// March controller, comparator, repair table
// and the BIST or functional request mux
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mbist_top
  import mbist_pkg::*;
#(
  parameter int ERR_LIMIT = 4,
  parameter int ADDR_END  = 2**MBIST_ADDR_WD - ERR_LIMIT - 1
) (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     start,
  output logic          busy,
  output logic          done,
  output logic          repair_fail,
  input  wire mem_req_t func_req,
  output mem_req_t      mem_req,
  input  wire data_t    mem_rdata,
  input  wire logic     scan_shift,
  input  wire logic     sdi,
  output logic          sdo
);

  logic     load_up;
  logic     load_dn;
  logic     step;
  logic     last;
  addr_t    bist_addr;
  mem_req_t bist_req;
  logic     rd_issue;
  data_t    exp_data;
  err_rpt_t err_rpt;
  mem_req_t src_req;
  addr_t    phys_addr;

  mbist_ctrl u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .addr     (bist_addr),
    .last     (last),
    .load_up  (load_up),
    .load_dn  (load_dn),
    .step     (step),
    .req      (bist_req),
    .rd_issue (rd_issue),
    .exp_data (exp_data),
    .busy     (busy),
    .done     (done)
  );

  mbist_addr_gen #(.ADDR_END(ADDR_END)) u_addr_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .load_up (load_up),
    .load_dn (load_dn),
    .step    (step),
    .addr    (bist_addr),
    .last    (last)
  );

  // Reports carry the logical address
  mbist_data_cmp u_data_cmp (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_issue (rd_issue),
    .exp_data (exp_data),
    .addr     (bist_addr),
    .rdata    (mem_rdata),
    .err_rpt  (err_rpt)
  );

  mbist_repair_addr #(
    .ERR_LIMIT (ERR_LIMIT),
    .ADDR_END  (ADDR_END)
  ) u_repair (
    .clk         (clk),
    .rst_n       (rst_n),
    .err_rpt     (err_rpt),
    .addr_in     (src_req.addr),
    .addr_out    (phys_addr),
    .repair_fail (repair_fail),
    .scan_shift  (scan_shift),
    .sdi         (sdi),
    .sdo         (sdo)
  );

  // BIST owns the port while busy
  assign src_req = busy ? bist_req : func_req;

  // Same-cycle remap on both paths
  always_comb begin
    mem_req      = src_req;
    mem_req.addr = phys_addr;
  end

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
////////////////////
// Testbench clock and reset
// 4 ns clock, power-on reset plus reset on request
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int HALF_PERIOD = 2,
  parameter int RST_CYCLES  = 2
) (
  input  wire logic rst_req,
  output logic      clk,
  output logic      rst_n
);

  logic por_n;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Power-on reset, released just after an edge
  initial begin
    por_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 por_n = 1'b1;
  end

  assign rst_n = por_n && !rst_req;

endmodule

`default_nettype wire

/* verif/mbist_asserts.sv */
////////////////////
// MBIST bound assertions
// Status, failure report and request sanity
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mbist_asserts
  import mbist_pkg::*;
(
  input wire logic     clk,
  input wire logic     rst_n,
  input wire logic     busy,
  input wire logic     done,
  input wire err_rpt_t err_rpt,
  input wire mem_req_t mem_req
);

  // Run status is one-hot or idle
  busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(busy && done))
    else $error("busy and done high together");

  // Reports only come from March reads
  rpt_in_run: assert property (@(posedge clk) disable iff (!rst_n)
    err_rpt.valid |-> busy)
    else $error("failure report outside of a run");

  we_needs_cs: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req.we |-> mem_req.cs)
    else $error("write enable without chip select");

endmodule

bind mbist_top mbist_asserts u_asserts (
  .clk     (clk),
  .rst_n   (rst_n),
  .busy    (busy),
  .done    (done),
  .err_rpt (err_rpt),
  .mem_req (mem_req)
);

`default_nettype wire

/* verif/mbist_tb.sv */
////////////////////
// MBIST testbench
// Table-driven March runs over a stuck-at SRAM model,
// scan-out, functional remap and reset checks
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mbist_tb
  import mbist_pkg::*;
();

  localparam int ERR_LIMIT  = 4;
  localparam int ADDR_END   = 2**MBIST_ADDR_WD - ERR_LIMIT - 1;
  localparam int MEM_WORDS  = 2**MBIST_ADDR_WD;
  localparam int SCAN_BITS  = ERR_LIMIT * MBIST_SLOT_WD;
  localparam int RUN_CYCLES = 6 * (ADDR_END + 1) + 2;
  localparam int ROW_CYCLES = 6 * MEM_WORDS + 200;
  localparam int MAX_FLT    = 8;
  localparam int NUM_ROWS   = 6;

  // Fault count, random, stuck value, base address, stuck bit, expected repair_fail
  typedef struct packed {
    logic [3:0] n_flt;
    logic       rnd;
    logic       stuck_val;
    addr_t      base;
    logic [4:0] bit_sel;
    logic       exp_fail;
  } row_t;

  logic     clk;
  logic     rst_n;
  logic     rst_req;
  logic     start;
  logic     busy;
  logic     done;
  logic     repair_fail;
  logic     scan_shift;
  logic     sdi;
  logic     sdo;
  mem_req_t func_req;
  mem_req_t mem_req;
  data_t    mem_rdata;

  // SRAM contents and per-row stuck-at faults
  data_t       mem [MEM_WORDS];
  addr_t       flt_addr [MAX_FLT];
  data_t       flt_mask [MAX_FLT];
  data_t       flt_val [MAX_FLT];
  int          n_flt;
  // Reference March state
  data_t       ref_mem [MEM_WORDS];
  addr_t       ref_tbl [ERR_LIMIT];
  int          ref_cnt;
  logic [31:0] lfsr_state;
  int          wd_epoch;
  row_t        rows [NUM_ROWS];

  tb_clkgen u_clkgen (
    .rst_req (rst_req),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  mbist_top dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .busy        (busy),
    .done        (done),
    .repair_fail (repair_fail),
    .func_req    (func_req),
    .mem_req     (mem_req),
    .mem_rdata   (mem_rdata),
    .scan_shift  (scan_shift),
    .sdi         (sdi),
    .sdo         (sdo)
  );

  ////////////////////
  // Models
  ////////////////////
  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Power-up contents, spare rows erased to ones
  function automatic data_t fill_word(input int a);
    if (a > ADDR_END) begin
      return '1;
    end
    return {a[7:0], ~a[8:0], a[8:0] ^ 9'h15a, a[5:0]};
  endfunction

  // Stuck bits override the stored word on read
  function automatic data_t apply_faults(input addr_t pa, input data_t d);
    data_t r;
    int    k;
    r = d;
    for (k = 0; k < n_flt; k++) begin
      if (flt_addr[k] == pa) begin
        r = (r & ~flt_mask[k]) | (flt_val[k] & flt_mask[k]);
      end
    end
    return r;
  endfunction

  // Lowest recorded entry picks the spare row
  function automatic addr_t ref_phys(input addr_t a);
    addr_t p;
    int    k;
    p = a;
    for (k = ref_cnt - 1; k >= 0; k--) begin
      if (ref_tbl[k] == a) begin
        p = addr_t'(ADDR_END + 1 + k);
      end
    end
    return p;
  endfunction

  // Synchronous SRAM, read data one cycle after the request
  initial begin
    mem_rdata <= '0;
  end

  always @(posedge clk) begin
    if (mem_req.cs) begin
      if (mem_req.we) begin
        mem[mem_req.addr] = mem_req.wdata;
      end else begin
        mem_rdata <= apply_faults(mem_req.addr, mem[mem_req.addr]);
      end
    end
  end

  // Whole March over a word model, recording each failing read
  task automatic run_ref_march();
    int    e;
    int    i;
    addr_t a;
    addr_t pa;
    data_t rv;
    data_t expv;
    ref_cnt = 0;
    for (i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = fill_word(i);
    end
    // W0 up, R0W1 up, R1W0 down, R0 down
    for (e = 0; e < 4; e++) begin
      expv = (e == 2) ? '1 : '0;
      for (i = 0; i <= ADDR_END; i++) begin
        a  = (e < 2) ? addr_t'(i) : addr_t'(ADDR_END - i);
        // Remap for this address is fixed before its read
        pa = ref_phys(a);
        if (e != 0) begin
          rv = apply_faults(pa, ref_mem[pa]);
          if ((rv != expv) && (ref_cnt < ERR_LIMIT)) begin
            ref_tbl[ref_cnt] = a;
            ref_cnt++;
          end
        end
        if (e == 1) begin
          ref_mem[pa] = '1;
        end else if (e != 3) begin
          ref_mem[pa] = '0;
        end
      end
    end
  endtask

  ////////////////////
  // Checks and drivers
  ////////////////////
  task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string what);
    if (act !== exp) begin
      $display("[ERROR] %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, act, exp);
      $display("TEST FAIL");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  // Per-row budget, restarted on each epoch
  initial begin : watchdog
    int seen;
    int cnt;
    seen = 0;
    cnt  = 0;
    forever begin
      @(posedge clk);
      if (wd_epoch != seen) begin
        seen = wd_epoch;
        cnt  = 0;
      end else begin
        cnt++;
      end
      if (cnt > ROW_CYCLES) begin
        $display("Watchdog expired: a test row ran past %0d cycles", ROW_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "Run did not finish in time");
      end
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    #1 rst_req = 1'b1;
    repeat (2) @(posedge clk);
    #1 rst_req = 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    #1 start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
  endtask

  // Build the row's fault list and power up the array
  task automatic load_faults(input row_t r);
    addr_t a;
    logic  dup;
    int    k;
    int    j;
    n_flt = 0;
    for (k = 0; k < r.n_flt; k++) begin
      if (r.rnd) begin
        // Distinct addresses below the last main row
        do begin
          a   = addr_t'(take_bits(MBIST_ADDR_WD) % ADDR_END);
          dup = 1'b0;
          for (j = 0; j < k; j++) begin
            if (flt_addr[j] == a) begin
              dup = 1'b1;
            end
          end
        end while (dup);
        flt_mask[k] = data_t'(1) << take_bits(5);
      end else begin
        a           = r.base + addr_t'(37 * k);
        flt_mask[k] = data_t'(1) << ((r.bit_sel + k) % 32);
      end
      flt_addr[k] = a;
      flt_val[k]  = r.stuck_val ? flt_mask[k] : '0;
      n_flt       = k + 1;
    end
    for (k = 0; k < MEM_WORDS; k++) begin
      mem[k] = fill_word(k);
    end
  endtask

  task automatic run_march();
    int cycles;
    pulse_start();
    check_eq(busy, 1'b1, "busy after start");
    cycles = 0;
    while (!done) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    check_eq(cycles, RUN_CYCLES, "cycles from start to done");
    check_eq(busy, 1'b0, "busy after done");
  endtask

  // Stream bit k is bit k mod 16 of entry k/16
  task automatic scan_check();
    logic [SCAN_BITS-1:0] exp_bits;
    int                   k;
    exp_bits = '0;
    for (k = 0; k < ref_cnt; k++) begin
      exp_bits[k*MBIST_SLOT_WD +: MBIST_SLOT_WD] = 16'(ref_tbl[k]);
    end
    @(posedge clk);
    #1 scan_shift = 1'b1;
    for (k = 0; k < SCAN_BITS; k++) begin
      @(negedge clk);
      check_eq(sdo, exp_bits[k], $sformatf("scan bit %0d", k));
      @(posedge clk);
      #1;
    end
    scan_shift = 1'b0;
  endtask

  // One functional access, reads compared against the fault model
  task automatic func_access(input addr_t a, input logic we, input data_t wd);
    addr_t exp_pa;
    exp_pa = ref_phys(a);
    @(posedge clk);
    #1 func_req = '{cs: 1'b1, we: we, addr: a, wdata: wd};
    @(negedge clk);
    check_eq(mem_req.cs, 1'b1, "functional cs");
    check_eq(mem_req.we, we, "functional we");
    check_eq(mem_req.addr, exp_pa, $sformatf("physical address for 0x%0h", a));
    @(posedge clk);
    #1 func_req = '0;
    if (!we) begin
      @(negedge clk);
      check_eq(mem_rdata, apply_faults(exp_pa, wd), $sformatf("read data at 0x%0h", a));
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin : main
    int    r;
    int    k;
    data_t wpat;
    rst_req    = 1'b0;
    start      = 1'b0;
    scan_shift = 1'b0;
    sdi        = 1'b0;
    func_req   = '0;
    lfsr_state = 32'h4d50;
    n_flt      = 0;
    ref_cnt    = 0;
    wd_epoch   = 0;

    rows[0] = '{4'd0, 1'b0, 1'b0, addr_t'(0), 5'd0, 1'b0};
    rows[1] = '{4'd1, 1'b0, 1'b1, addr_t'(5), 5'd0, 1'b0};
    rows[2] = '{4'd3, 1'b1, 1'b1, addr_t'(0), 5'd0, 1'b0};
    rows[3] = '{4'd4, 1'b1, 1'b1, addr_t'(0), 5'd0, 1'b0};
    rows[4] = '{4'd6, 1'b1, 1'b1, addr_t'(0), 5'd0, 1'b1};
    // Stuck-at-0 also fails again on the erased spare in R0
    rows[5] = '{4'd2, 1'b0, 1'b0, addr_t'(100), 5'd31, 1'b0};

    wait (rst_n === 1'b1);

    for (r = 0; r < NUM_ROWS; r++) begin
      wd_epoch++;
      load_faults(rows[r]);
      run_ref_march();
      apply_reset();
      run_march();
      check_eq(repair_fail, rows[r].exp_fail, $sformatf("repair_fail in row %0d", r));
      scan_check();
      // Write then read each faulty address and one clean row
      for (k = 0; k < n_flt; k++) begin
        wpat = take_bits(32);
        func_access(flt_addr[k], 1'b1, wpat);
        func_access(flt_addr[k], 1'b0, wpat);
      end
      wpat = take_bits(32);
      func_access(addr_t'(ADDR_END), 1'b1, wpat);
      func_access(addr_t'(ADDR_END), 1'b0, wpat);
    end

    // Reset once R0W1 has filled the table
    wd_epoch++;
    load_faults(rows[4]);
    apply_reset();
    pulse_start();
    repeat (3 * (ADDR_END + 1) + 8) @(posedge clk);
    #1 rst_req = 1'b1;
    @(negedge clk);
    check_eq(busy, 1'b0, "busy in reset");
    check_eq(done, 1'b0, "done in reset");
    check_eq(repair_fail, 1'b0, "repair_fail in reset");
    check_eq(mem_req.cs, 1'b0, "mem_req cs in reset");
    @(posedge clk);
    #1 rst_req = 1'b0;
    ref_cnt = 0;
    scan_check();

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
logic/mbist_pkg.sv
logic/mbist_addr_gen.sv
logic/mbist_ctrl.sv
logic/mbist_data_cmp.sv
logic/mbist_repair_addr.sv
logic/mbist_top.sv
verif/tb_clkgen.sv
verif/mbist_asserts.sv
verif/mbist_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the MBIST testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mbist_tb -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vmbist_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
